// ==== dv/bf16_ref.svh ====
`ifndef BF16_REF_SVH
`define BF16_REF_SVH

// Expected {bf16, invalid, overflow, underflow, inexact} for one FP32 word
function automatic logic [19:0] bf16_ref(input logic [31:0] x);
    logic        sign;
    logic [7:0]  exp;
    logic [22:0] man;
    logic [31:0] biased;  // Magnitude plus rounding bias
    logic        lost;    // Any of the 16 dropped bits set
    sign = x[31];
    exp  = x[30:23];
    man  = x[22:0];
    lost = |x[15:0];
    if (exp == 8'hFF && man != '0) begin
        return {16'h7FC0, 4'b1000};                // Any NaN, canonical quiet NaN
    end
    if (exp == 8'hFF || (exp == 8'h00 && man == '0)) begin
        return {x[31:16], 4'b0000};                // Inf and zero keep their sign
    end
    if (exp == 8'h00) begin
        return {sign, 15'h0000, 4'b0011};          // Subnormal flushed to signed zero
    end
    // Just under half an ULP, plus one when the kept LSB is odd
    biased = {1'b0, x[30:0]} + 32'h0000_7FFF + {31'b0, x[16]};
    if (biased[30:23] == 8'hFF) begin
        return {sign, 8'hFF, 7'h00, 4'b0101};      // Past max finite, inf
    end
    return {sign, biased[30:16], 3'b000, lost};
endfunction

// Fibonacci LFSR, x^32 + x^22 + x^2 + x + 1
// Shifts left, feedback enters at bit 0
function automatic logic [31:0] lfsr_step(input logic [31:0] state);
    logic fb;
    fb = state[31] ^ state[21] ^ state[1] ^ state[0];
    return {state[30:0], fb};
endfunction

`endif

// ==== dv/tb_fp32_to_bf16_array.sv ====
`timescale 1ns/1ns

module tb_fp32_to_bf16_array;

    `include "bf16_ref.svh"

    localparam int WAIT_LIMIT = 40;  // Cycles per handshake wait
    localparam int POLL_LIMIT = 20;  // STATUS reads before giving up

    logic                         gated_clk;
    logic                         reset;
    logic [bf16_pkg::ADDR_W-1:0]  awaddr;
    logic                         awvalid;
    logic                         awready;
    logic [31:0]                  wdata;
    logic                         wvalid;
    logic                         wready;
    logic [1:0]                   bresp;
    logic                         bvalid;
    logic                         bready;
    logic [bf16_pkg::ADDR_W-1:0]  araddr;
    logic                         arvalid;
    logic                         arready;
    logic [31:0]                  rdata;
    logic [1:0]                   rresp;
    logic                         rvalid;
    logic                         rready;

    logic [31:0] ops [bf16_pkg::NUM_LANES]; // Operands of the current batch
    logic [31:0] first_status;              // First STATUS read after START
    logic [31:0] lfsr_q;
    logic [31:0] rd;
    logic [1:0]  resp;
    int          drain;

    // Checks queued by the stimulus, drained by the compare process
    string       name_q [$];
    logic [31:0] exp_q  [$];
    logic [31:0] act_q  [$];
    bit          end_q  [$];                // Entry closes a test
    string       cur_name;
    logic [31:0] cur_exp;
    logic [31:0] cur_act;
    bit          cur_end;
    int          test_checks = 0;
    int          test_errs   = 0;
    int          tests_run   = 0;
    int          tests_bad   = 0;
    int          all_checks  = 0;
    int          all_errs    = 0;

    fp32_to_bf16_array u_dut (
        .gated_clk, .reset,
        .s_awaddr_i  (awaddr),  .s_awvalid_i (awvalid), .s_awready_o (awready),
        .s_wdata_i   (wdata),   .s_wvalid_i  (wvalid),  .s_wready_o  (wready),
        .s_bresp_o   (bresp),   .s_bvalid_o  (bvalid),  .s_bready_i  (bready),
        .s_araddr_i  (araddr),  .s_arvalid_i (arvalid), .s_arready_o (arready),
        .s_rdata_o   (rdata),   .s_rresp_o   (rresp),   .s_rvalid_o  (rvalid),
        .s_rready_i  (rready)
    );

    initial begin
        gated_clk = 1'b0;
        forever #5 gated_clk = ~gated_clk;      // 10 ns period
    end

    always @(posedge gated_clk) begin
        while (name_q.size() > 0) begin
            cur_name = name_q.pop_front();
            cur_exp  = exp_q.pop_front();
            cur_act  = act_q.pop_front();
            cur_end  = end_q.pop_front();
            if (cur_end) begin
                if (test_errs == 0) begin
                    $display("PASS %s (%0d checks)", cur_name, test_checks);
                end else begin
                    $display("FAIL %s (%0d of %0d checks wrong)", cur_name, test_errs,
                             test_checks);
                    tests_bad++;
                end
                tests_run++;
                all_checks += test_checks;
                all_errs   += test_errs;
                test_checks = 0;
                test_errs   = 0;
            end else begin
                test_checks++;
                if (cur_act !== cur_exp) begin
                    $display("ERR %s: expected 0x%08h, actual 0x%08h", cur_name, cur_exp,
                             cur_act);
                    test_errs++;
                end
            end
        end
    end

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        name_q.push_back(name);
        exp_q.push_back(expected);
        act_q.push_back(actual);
        end_q.push_back(1'b0);
    endtask

    task automatic close_test(input string name);
        name_q.push_back(name);
        exp_q.push_back(32'h0);
        act_q.push_back(32'h0);
        end_q.push_back(1'b1);
    endtask

    task automatic abort_run(input string why);
        $display("ABORT: %s", why);
        $display("tests failed");
        $finish;
    endtask

    task automatic axi_write(input logic [bf16_pkg::ADDR_W-1:0] addr, input logic [31:0] data,
                             output logic [1:0] wr_resp);
        int n;
        @(posedge gated_clk);
        #1;
        awaddr  = addr;
        wdata   = data;
        awvalid = 1'b1;
        wvalid  = 1'b1;
        bready  = 1'b1;
        n = 0;
        @(negedge gated_clk);
        while (!(awready && wready) && n < WAIT_LIMIT) begin
            @(negedge gated_clk);
            n++;
        end
        if (!(awready && wready)) begin
            abort_run("AXI write was never accepted");
        end else begin
            @(posedge gated_clk);                  // AW and W handshake
            #1;
            awvalid = 1'b0;
            wvalid  = 1'b0;
            n = 0;
            @(negedge gated_clk);
            while (!bvalid && n < WAIT_LIMIT) begin
                @(negedge gated_clk);
                n++;
            end
            if (!bvalid) begin
                abort_run("no AXI write response");
            end else begin
                wr_resp = bresp;
                @(posedge gated_clk);              // B handshake
                #1;
                bready = 1'b0;
            end
        end
    endtask

    task automatic axi_read(input logic [bf16_pkg::ADDR_W-1:0] addr, output logic [31:0] data,
                            output logic [1:0] rd_resp);
        int n;
        @(posedge gated_clk);
        #1;
        araddr  = addr;
        arvalid = 1'b1;
        rready  = 1'b1;
        n = 0;
        @(negedge gated_clk);
        while (!arready && n < WAIT_LIMIT) begin
            @(negedge gated_clk);
            n++;
        end
        if (!arready) begin
            abort_run("AXI read was never accepted");
        end else begin
            @(posedge gated_clk);
            #1;
            arvalid = 1'b0;
            n = 0;
            @(negedge gated_clk);
            while (!rvalid && n < WAIT_LIMIT) begin
                @(negedge gated_clk);
                n++;
            end
            if (!rvalid) begin
                abort_run("no AXI read data");
            end else begin
                data    = rdata;
                rd_resp = rresp;
                @(posedge gated_clk);
                #1;
                rready = 1'b0;
            end
        end
    endtask

    function automatic logic [bf16_pkg::ADDR_W-1:0] operand_addr(input int i);
        return bf16_pkg::REG_OPERAND_BASE + {i[bf16_pkg::ADDR_W-3:0], 2'b00};
    endfunction

    task automatic set_ops(input logic [31:0] a, input logic [31:0] b,
                           input logic [31:0] c, input logic [31:0] d);
        ops[0] = a;
        ops[1] = b;
        ops[2] = c;
        ops[3] = d;
    endtask

    // One random bit per LFSR step
    task automatic next_rand_word(output logic [31:0] w);
        w = '0;
        for (int b = 0; b < 32; b++) begin
            lfsr_q = lfsr_step(lfsr_q);
            w = {w[30:0], lfsr_q[0]};
        end
    endtask

    // Load operands, START, poll DONE, compare every lane
    task automatic run_batch(input string name, input bit double_start);
        logic [31:0] status;
        logic [63:0] res_all;
        logic [31:0] flags;
        logic [1:0]  r;
        logic [19:0] expect_rf;
        int          polls;
        for (int i = 0; i < bf16_pkg::NUM_LANES; i++) begin
            axi_write(operand_addr(i), ops[i], r);
        end
        axi_write(bf16_pkg::REG_CTRL, 32'h1, r);
        if (double_start) begin
            axi_write(bf16_pkg::REG_CTRL, 32'h1, r);    // Lands mid-batch
            check_value($sformatf("%s second START bresp", name), 32'(bf16_pkg::RESP_OKAY),
                        32'(r));
        end
        axi_read(bf16_pkg::REG_STATUS, status, r);
        first_status = status;
        polls = 0;
        while (!status[1] && polls < POLL_LIMIT) begin
            axi_read(bf16_pkg::REG_STATUS, status, r);
            polls++;
        end
        if (!status[1]) begin
            abort_run($sformatf("%s: DONE was never set", name));
        end else begin
            axi_read(bf16_pkg::REG_RESULT01, res_all[31:0], r);
            axi_read(bf16_pkg::REG_RESULT23, res_all[63:32], r);
            axi_read(bf16_pkg::REG_FLAGS, flags, r);
            for (int i = 0; i < bf16_pkg::NUM_LANES; i++) begin
                expect_rf = bf16_ref(ops[i]);
                check_value($sformatf("%s lane %0d result", name, i),
                            32'(expect_rf[19:4]), 32'(res_all[16*i +: 16]));
                check_value($sformatf("%s lane %0d flags", name, i),
                            32'(expect_rf[3:0]), 32'(flags[4*i +: 4]));
            end
        end
    endtask

    initial begin
        reset   = 1'b0;
        awaddr  = '0;
        awvalid = 1'b0;
        wdata   = '0;
        wvalid  = 1'b0;
        bready  = 1'b0;
        araddr  = '0;
        arvalid = 1'b0;
        rready  = 1'b0;
        lfsr_q  = 32'd71391;
        repeat (4) @(posedge gated_clk);
        #1;
        reset = 1'b1;

        axi_read(bf16_pkg::REG_STATUS, rd, resp);      // Idle, not done
        check_value("reset status", 32'h0, rd);
        close_test("reset");

        set_ops(32'h0000_0000, 32'h8000_0000, 32'h7F80_0000, 32'hFF80_0000);
        run_batch("specials zero inf", 1'b0);
        set_ops(32'h7FC0_0000, 32'h7F80_0001, 32'hFFFF_FFFF, 32'h3F80_0000);
        run_batch("specials nan", 1'b0);
        close_test("specials");

        set_ops(32'h3F80_8000, 32'h3F81_8000, 32'h3F80_8001, 32'h3FFF_FFFF);
        run_batch("rounding ties", 1'b0);
        set_ops(32'hBF81_8000, 32'h3F80_7FFF, 32'h3F7F_FFFF, 32'h4040_8000);
        run_batch("rounding carry", 1'b0);
        close_test("rounding");

        set_ops(32'h7F7F_FFFF, 32'hFF7F_FFFF, 32'h0000_0001, 32'h807F_FFFF);
        run_batch("range edges", 1'b0);
        set_ops(32'h7F7F_7FFF, 32'h7F7F_8000, 32'h0040_0000, 32'h8000_0001);
        run_batch("range near max", 1'b0);
        close_test("overflow_underflow");

        for (int b = 0; b < 64; b++) begin
            for (int i = 0; i < bf16_pkg::NUM_LANES; i++) begin
                next_rand_word(ops[i]);
            end
            run_batch($sformatf("random batch %0d", b), 1'b0);
        end
        close_test("random");

        set_ops(32'h4049_0FDB, 32'hC2F6_E979, 32'h3EAA_AAAB, 32'h4700_0080);
        run_batch("protocol", 1'b0);
        check_value("status after START", 32'h1, first_status); // BUSY up, DONE cleared
        axi_read(bf16_pkg::REG_STATUS, rd, resp);
        check_value("status when done", 32'h2, rd);
        for (int i = 0; i < bf16_pkg::NUM_LANES; i++) begin
            axi_read(operand_addr(i), rd, resp);
            check_value($sformatf("operand %0d readback", i), ops[i], rd);
        end
        run_batch("protocol double START", 1'b1);
        axi_read(bf16_pkg::REG_STATUS, rd, resp);      // No second batch started
        check_value("status after double START", 32'h2, rd);
        axi_read(6'h24, rd, resp);
        check_value("unmapped 0x24 data", 32'h0, rd);
        check_value("unmapped 0x24 resp", 32'(bf16_pkg::RESP_SLVERR), 32'(resp));
        axi_read(6'h02, rd, resp);                     // Unaligned operand offset
        check_value("unmapped 0x02 data", 32'h0, rd);
        check_value("unmapped 0x02 resp", 32'(bf16_pkg::RESP_SLVERR), 32'(resp));
        close_test("protocol");

        drain = 0;
        while (name_q.size() > 0 && drain < WAIT_LIMIT) begin
            @(negedge gated_clk);
            drain++;
        end
        if (name_q.size() > 0) begin
            abort_run("compare queue never drained");
        end else begin
            $display("%0d tests run, %0d failing, %0d checks, %0d errors", tests_run,
                     tests_bad, all_checks, all_errs);
            if (tests_bad == 0 && all_errs == 0) begin
                $display("all tests passed");
            end else begin
                $display("tests failed");
            end
            $finish;
        end
    end

endmodule

// ==== logic/axil_conv_regs.sv ====
`timescale 1ns/1ns

module axil_conv_regs (
    input  logic                              gated_clk,
    input  logic                              reset,
    // AXI4-Lite slave
    input  logic [bf16_pkg::ADDR_W-1:0]       s_awaddr_i,
    input  logic                              s_awvalid_i,
    output logic                              s_awready_o,
    input  logic [31:0]                       s_wdata_i,
    input  logic                              s_wvalid_i,
    output logic                              s_wready_o,
    output logic [1:0]                        s_bresp_o,
    output logic                              s_bvalid_o,
    input  logic                              s_bready_i,
    input  logic [bf16_pkg::ADDR_W-1:0]       s_araddr_i,
    input  logic                              s_arvalid_i,
    output logic                              s_arready_o,
    output logic [31:0]                       s_rdata_o,
    output logic [1:0]                        s_rresp_o,
    output logic                              s_rvalid_o,
    input  logic                              s_rready_i,
    // Engine side
    output bf16_pkg::fp32_word_u              operands_o [bf16_pkg::NUM_LANES],
    output logic                              start_o,
    input  logic                              busy_i,
    input  logic                              batch_done_i,
    input  logic [15:0]                       results_i  [bf16_pkg::NUM_LANES],
    input  bf16_pkg::fconv_flags_t            flags_i    [bf16_pkg::NUM_LANES]
);

    logic                   wr_accept;
    logic                   rd_accept;
    logic                   done_q;                          // Sticky DONE bit
    logic [15:0]            results_q [bf16_pkg::NUM_LANES]; // Latched on batch_done_i
    bf16_pkg::fconv_flags_t flags_q   [bf16_pkg::NUM_LANES];
    logic [31:0]            flags_word;
    logic [31:0]            rd_data;
    logic                   rd_mapped;

    // Operand words live at 0x00..0x0C, word aligned
    function automatic logic is_operand(input logic [bf16_pkg::ADDR_W-1:0] addr);
        return (addr[bf16_pkg::ADDR_W-1:4] == '0) && (addr[1:0] == 2'b00);
    endfunction

    function automatic logic is_mapped(input logic [bf16_pkg::ADDR_W-1:0] addr);
        return is_operand(addr) || addr == bf16_pkg::REG_CTRL ||
               addr == bf16_pkg::REG_STATUS || addr == bf16_pkg::REG_RESULT01 ||
               addr == bf16_pkg::REG_RESULT23 || addr == bf16_pkg::REG_FLAGS;
    endfunction

    // Address and data taken together, one write outstanding
    assign wr_accept   = s_awvalid_i && s_wvalid_i && !s_bvalid_o;
    assign s_awready_o = wr_accept;
    assign s_wready_o  = wr_accept;

    assign s_arready_o = !s_rvalid_o;          // Free when no response pending
    assign rd_accept   = s_arvalid_i && s_arready_o;

    // START ignored while a batch runs
    assign start_o = wr_accept && (s_awaddr_i == bf16_pkg::REG_CTRL) && s_wdata_i[0] && !busy_i;

    always_ff @(posedge gated_clk) begin
        if (wr_accept && is_operand(s_awaddr_i)) begin
            operands_o[s_awaddr_i[3:2]].raw <= s_wdata_i;
        end
    end

    always_ff @(posedge gated_clk or negedge reset) begin
        if (!reset) begin
            s_bvalid_o <= 1'b0;
            s_bresp_o  <= bf16_pkg::RESP_OKAY;
        end else if (wr_accept) begin
            s_bvalid_o <= 1'b1;
            s_bresp_o  <= is_mapped(s_awaddr_i) ? bf16_pkg::RESP_OKAY : bf16_pkg::RESP_SLVERR;
        end else if (s_bready_i) begin
            s_bvalid_o <= 1'b0;
        end
    end

    always_ff @(posedge gated_clk or negedge reset) begin
        if (!reset) begin
            done_q <= 1'b0;
        end else if (start_o) begin
            done_q <= 1'b0;                    // Next batch clears DONE
        end else if (batch_done_i) begin
            done_q <= 1'b1;
        end
    end

    always_ff @(posedge gated_clk) begin
        if (batch_done_i) begin
            results_q <= results_i;
            flags_q   <= flags_i;
        end
    end

    always_comb begin
        flags_word = '0;
        for (int i = 0; i < bf16_pkg::NUM_LANES; i++) begin
            flags_word[4*i +: 4] = flags_q[i];
        end
    end

    always_comb begin
        rd_mapped = is_mapped(s_araddr_i);
        rd_data   = '0;
        if (is_operand(s_araddr_i)) begin
            rd_data = operands_o[s_araddr_i[3:2]].raw;
        end else begin
            case (s_araddr_i)
                bf16_pkg::REG_STATUS:   rd_data = {30'b0, done_q, busy_i};
                bf16_pkg::REG_RESULT01: rd_data = {results_q[1], results_q[0]};
                bf16_pkg::REG_RESULT23: rd_data = {results_q[3], results_q[2]};
                bf16_pkg::REG_FLAGS:    rd_data = flags_word;
                default:                rd_data = '0; // CTRL and holes read zero
            endcase
        end
    end

    always_ff @(posedge gated_clk or negedge reset) begin
        if (!reset) begin
            s_rvalid_o <= 1'b0;
            s_rdata_o  <= '0;
            s_rresp_o  <= bf16_pkg::RESP_OKAY;
        end else if (rd_accept) begin
            s_rvalid_o <= 1'b1;
            s_rdata_o  <= rd_data;
            s_rresp_o  <= rd_mapped ? bf16_pkg::RESP_OKAY : bf16_pkg::RESP_SLVERR;
        end else if (s_rready_i) begin
            s_rvalid_o <= 1'b0;
        end
    end

    // Write response only follows a handshake on AW and W
    a_bvalid_cause: assert property (@(posedge gated_clk) disable iff (!reset)
        $rose(s_bvalid_o) |-> $past(wr_accept));

endmodule

// ==== logic/bf16_pkg.sv ====
package bf16_pkg;

    localparam int NUM_LANES = 4;                  // Conversion lanes
    localparam int ADDR_W    = 6;                  // AXI4-Lite byte address width

    // Register map, byte offsets
    localparam logic [ADDR_W-1:0] REG_OPERAND_BASE = 6'h00; // Four operand words
    localparam logic [ADDR_W-1:0] REG_CTRL         = 6'h10; // Bit 0 START, write-only
    localparam logic [ADDR_W-1:0] REG_STATUS       = 6'h14; // Bit 0 BUSY, bit 1 DONE
    localparam logic [ADDR_W-1:0] REG_RESULT01     = 6'h18; // Lanes 0 and 1
    localparam logic [ADDR_W-1:0] REG_RESULT23     = 6'h1C; // Lanes 2 and 3
    localparam logic [ADDR_W-1:0] REG_FLAGS        = 6'h20; // Four bits per lane

    localparam logic [1:0] RESP_OKAY   = 2'b00;
    localparam logic [1:0] RESP_SLVERR = 2'b10;

    localparam logic [15:0] BF16_QNAN = 16'h7FC0;  // Canonical quiet NaN
    localparam logic [7:0]  EXP_MAX   = 8'hFF;     // Inf / NaN exponent

    typedef struct packed {
        logic        sign;
        logic [7:0]  exp;
        logic [22:0] man;
    } fp32_fields_t;

    // Raw word on the register side, field view inside the lane
    typedef union packed {
        logic [31:0]  raw;
        fp32_fields_t fields;
    } fp32_word_u;

    typedef struct packed {
        logic invalid;   // NaN input
        logic overflow;  // Rounded past the largest finite
        logic underflow; // Subnormal flushed to zero
        logic inexact;   // Bits lost
    } fconv_flags_t;

    typedef struct packed {
        fp32_word_u operand;
    } lane_req_t;

    typedef struct packed {
        logic [15:0]  result;
        fconv_flags_t flags;
    } lane_rsp_t;

endpackage

// ==== logic/bf16_round_lane.sv ====
`timescale 1ns/1ns

module bf16_round_lane (
    input  logic                 gated_clk,
    input  logic                 reset,
    input  logic                 req_valid_i,
    output logic                 req_ready_o,
    input  bf16_pkg::lane_req_t  req_i,
    output logic                 rsp_valid_o,
    input  logic                 rsp_ready_i,
    output bf16_pkg::lane_rsp_t  rsp_o
);

    // Decoded operand held between the stages
    typedef struct packed {
        logic       sign;
        logic [7:0] exp;
        logic [6:0] man;     // Kept mantissa bits 22:16
        logic       guard;   // Mantissa bit 15
        logic       sticky;  // OR of bits 14:0
        logic       is_zero;
        logic       is_sub;
        logic       is_inf;
        logic       is_nan;
    } s1_data_t;

    bf16_pkg::fp32_fields_t f;
    s1_data_t               s1_next;
    s1_data_t               s1_q;
    logic                   s1_valid;
    logic                   s2_load;
    logic                   round_up;
    logic [14:0]            rounded;   // {exp, man} after increment
    bf16_pkg::lane_rsp_t    rsp_next;

    assign f = req_i.operand.fields;

    always_comb begin
        s1_next.sign    = f.sign;
        s1_next.exp     = f.exp;
        s1_next.man     = f.man[22:16];
        s1_next.guard   = f.man[15];
        s1_next.sticky  = |f.man[14:0];
        s1_next.is_zero = (f.exp == 8'h00) && (f.man == '0);
        s1_next.is_sub  = (f.exp == 8'h00) && (f.man != '0);
        s1_next.is_inf  = (f.exp == bf16_pkg::EXP_MAX) && (f.man == '0);
        s1_next.is_nan  = (f.exp == bf16_pkg::EXP_MAX) && (f.man != '0);
    end

    // Output stage moves when empty or drained this cycle
    assign s2_load     = s1_valid && (!rsp_valid_o || rsp_ready_i);
    assign req_ready_o = !s1_valid || s2_load;

    always_ff @(posedge gated_clk or negedge reset) begin
        if (!reset) begin
            s1_valid <= 1'b0;
        end else if (req_ready_o) begin
            s1_valid <= req_valid_i;
        end
    end

    always_ff @(posedge gated_clk) begin
        if (req_valid_i && req_ready_o) begin
            s1_q <= s1_next;               // Only runs on a real request
        end
    end

    // RNE: halfway goes to even kept LSB
    assign round_up = s1_q.guard && (s1_q.sticky || s1_q.man[0]);
    assign rounded  = {s1_q.exp, s1_q.man} + 15'(round_up); // Carry bumps exp

    always_comb begin
        rsp_next.flags = '0;
        if (s1_q.is_nan) begin
            rsp_next.result        = bf16_pkg::BF16_QNAN;
            rsp_next.flags.invalid = 1'b1;
        end else if (s1_q.is_inf || s1_q.is_zero) begin
            rsp_next.result = {s1_q.sign, s1_q.exp, 7'h00}; // Signed pass-through
        end else if (s1_q.is_sub) begin
            rsp_next.result          = {s1_q.sign, 15'h0000}; // Flush to zero
            rsp_next.flags.underflow = 1'b1;
            rsp_next.flags.inexact   = 1'b1;
        end else if (rounded[14:7] == bf16_pkg::EXP_MAX) begin
            rsp_next.result         = {s1_q.sign, bf16_pkg::EXP_MAX, 7'h00};
            rsp_next.flags.overflow = 1'b1;
            rsp_next.flags.inexact  = 1'b1;
        end else begin
            rsp_next.result        = {s1_q.sign, rounded};
            rsp_next.flags.inexact = s1_q.guard || s1_q.sticky;
        end
    end

    always_ff @(posedge gated_clk or negedge reset) begin
        if (!reset) begin
            rsp_valid_o <= 1'b0;
        end else if (s2_load) begin
            rsp_valid_o <= 1'b1;
        end else if (rsp_ready_i) begin
            rsp_valid_o <= 1'b0;
        end
    end

    always_ff @(posedge gated_clk) begin
        if (s2_load) begin
            rsp_o <= rsp_next;
        end
    end

    // Held response must not change under back-pressure
    a_rsp_stable: assert property (@(posedge gated_clk) disable iff (!reset)
        rsp_valid_o && !rsp_ready_i |=> rsp_valid_o && $stable(rsp_o));

endmodule

// ==== logic/fp32_to_bf16_array.sv ====
`timescale 1ns/1ns

module fp32_to_bf16_array (
    input  logic                          gated_clk,
    input  logic                          reset,
    input  logic [bf16_pkg::ADDR_W-1:0]   s_awaddr_i,
    input  logic                          s_awvalid_i,
    output logic                          s_awready_o,
    input  logic [31:0]                   s_wdata_i,
    input  logic                          s_wvalid_i,
    output logic                          s_wready_o,
    output logic [1:0]                    s_bresp_o,
    output logic                          s_bvalid_o,
    input  logic                          s_bready_i,
    input  logic [bf16_pkg::ADDR_W-1:0]   s_araddr_i,
    input  logic                          s_arvalid_i,
    output logic                          s_arready_o,
    output logic [31:0]                   s_rdata_o,
    output logic [1:0]                    s_rresp_o,
    output logic                          s_rvalid_o,
    input  logic                          s_rready_i
);

    bf16_pkg::fp32_word_u           operands [bf16_pkg::NUM_LANES];
    logic                           start;
    logic                           busy;
    logic                           batch_done;
    logic [bf16_pkg::NUM_LANES-1:0] req_valid;
    logic [bf16_pkg::NUM_LANES-1:0] req_ready;
    bf16_pkg::lane_req_t            req      [bf16_pkg::NUM_LANES];
    logic [bf16_pkg::NUM_LANES-1:0] rsp_valid;
    logic [bf16_pkg::NUM_LANES-1:0] rsp_ready;
    bf16_pkg::lane_rsp_t            rsp      [bf16_pkg::NUM_LANES];
    logic [15:0]                    results  [bf16_pkg::NUM_LANES];
    bf16_pkg::fconv_flags_t         flags    [bf16_pkg::NUM_LANES];

    axil_conv_regs u_regs (
        .gated_clk, .reset,
        .s_awaddr_i, .s_awvalid_i, .s_awready_o,
        .s_wdata_i, .s_wvalid_i, .s_wready_o,
        .s_bresp_o, .s_bvalid_o, .s_bready_i,
        .s_araddr_i, .s_arvalid_i, .s_arready_o,
        .s_rdata_o, .s_rresp_o, .s_rvalid_o, .s_rready_i,
        .operands_o   (operands),
        .start_o      (start),
        .busy_i       (busy),
        .batch_done_i (batch_done),
        .results_i    (results),
        .flags_i      (flags)
    );

    operand_dispatcher u_dispatch (
        .gated_clk, .reset,
        .start_i      (start),
        .operands_i   (operands),
        .req_valid_o  (req_valid),
        .req_ready_i  (req_ready),
        .req_o        (req),
        .batch_done_i (batch_done),
        .busy_o       (busy)
    );

    for (genvar i = 0; i < bf16_pkg::NUM_LANES; i++) begin : g_lane
        bf16_round_lane u_lane (
            .gated_clk, .reset,
            .req_valid_i (req_valid[i]),
            .req_ready_o (req_ready[i]),
            .req_i       (req[i]),
            .rsp_valid_o (rsp_valid[i]),
            .rsp_ready_i (rsp_ready[i]),
            .rsp_o       (rsp[i])
        );
    end

    result_collector u_collect (
        .gated_clk, .reset,
        .rsp_valid_i  (rsp_valid),
        .rsp_ready_o  (rsp_ready),
        .rsp_i        (rsp),
        .results_o    (results),
        .flags_o      (flags),
        .batch_done_o (batch_done)
    );

endmodule

// ==== logic/operand_dispatcher.sv ====
`timescale 1ns/1ns

module operand_dispatcher (
    input  logic                                gated_clk,
    input  logic                                reset,
    input  logic                                start_i,
    input  bf16_pkg::fp32_word_u                operands_i [bf16_pkg::NUM_LANES],
    output logic [bf16_pkg::NUM_LANES-1:0]      req_valid_o,
    input  logic [bf16_pkg::NUM_LANES-1:0]      req_ready_i,
    output bf16_pkg::lane_req_t                 req_o      [bf16_pkg::NUM_LANES],
    input  logic                                batch_done_i,
    output logic                                busy_o
);

    logic [bf16_pkg::NUM_LANES-1:0] pending; // Request not yet taken by its lane

    assign req_valid_o = pending;

    always_ff @(posedge gated_clk or negedge reset) begin
        if (!reset) begin
            pending <= '0;
        end else if (start_i) begin
            pending <= '1;                   // Every lane gets one operand
        end else begin
            pending <= pending & ~req_ready_i; // Drop on transfer
        end
    end

    // Operand snapshot so host writes mid-batch do not disturb requests
    always_ff @(posedge gated_clk) begin
        if (start_i) begin
            for (int i = 0; i < bf16_pkg::NUM_LANES; i++) begin
                req_o[i].operand <= operands_i[i];
            end
        end
    end

    always_ff @(posedge gated_clk or negedge reset) begin
        if (!reset) begin
            busy_o <= 1'b0;
        end else if (start_i) begin
            busy_o <= 1'b1;
        end else if (batch_done_i) begin
            busy_o <= 1'b0;                  // Collector saw all four
        end
    end

    // Register block must filter START while busy
    a_no_start_busy: assert property (@(posedge gated_clk) disable iff (!reset)
        start_i |-> !busy_o);

endmodule

// ==== logic/result_collector.sv ====
`timescale 1ns/1ns

module result_collector (
    input  logic                               gated_clk,
    input  logic                               reset,
    input  logic [bf16_pkg::NUM_LANES-1:0]     rsp_valid_i,
    output logic [bf16_pkg::NUM_LANES-1:0]     rsp_ready_o,
    input  bf16_pkg::lane_rsp_t                rsp_i     [bf16_pkg::NUM_LANES],
    output logic [15:0]                        results_o [bf16_pkg::NUM_LANES],
    output bf16_pkg::fconv_flags_t             flags_o   [bf16_pkg::NUM_LANES],
    output logic                               batch_done_o
);

    logic [bf16_pkg::NUM_LANES-1:0] taken; // Lane answered this batch
    logic [bf16_pkg::NUM_LANES-1:0] take;

    assign rsp_ready_o  = ~taken;          // One response per lane
    assign take         = rsp_valid_i & rsp_ready_o;
    assign batch_done_o = &taken;          // Cycle after the last take

    always_ff @(posedge gated_clk or negedge reset) begin
        if (!reset) begin
            taken <= '0;
        end else if (batch_done_o) begin
            taken <= '0;                   // Ready for next batch
        end else begin
            taken <= taken | take;
        end
    end

    always_ff @(posedge gated_clk) begin
        for (int i = 0; i < bf16_pkg::NUM_LANES; i++) begin
            if (take[i]) begin
                results_o[i] <= rsp_i[i].result;
                flags_o[i]   <= rsp_i[i].flags;
            end
        end
    end

    for (genvar i = 0; i < bf16_pkg::NUM_LANES; i++) begin : g_chk
        // Taken lane offers no second response before batch_done_o
        a_take_once: assert property (@(posedge gated_clk) disable iff (!reset)
            taken[i] |-> !rsp_valid_i[i]);
    end

endmodule

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build the FP32-to-BF16 array testbench with Verilator, run it, check the log
set -u

cd "$(dirname "$0")" || exit 1

BUILD_DIR=build
LOG="$BUILD_DIR/sim.log"

if ! mkdir -p "$BUILD_DIR"; then
    echo "cannot create $BUILD_DIR"
    exit 1
fi

if ! verilator --binary --assert -j 0 -f sim.f \
        --top-module tb_fp32_to_bf16_array -Mdir "$BUILD_DIR/obj"; then
    echo "verilator build failed"
    exit 1
fi

"./$BUILD_DIR/obj/Vtb_fp32_to_bf16_array" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ "$status" -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -qx "all tests passed" "$LOG"; then
    exit 0
fi
echo "pass message not found in $LOG"
exit 1

// ==== sim.f ====
+incdir+dv
logic/bf16_pkg.sv
logic/axil_conv_regs.sv
logic/operand_dispatcher.sv
logic/bf16_round_lane.sv
logic/result_collector.sv
logic/fp32_to_bf16_array.sv
dv/tb_fp32_to_bf16_array.sv
